//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
LINT      := --lint-only --timing --assert -Wall
TOP       := tb_tracking_loops
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

lint:
	$(VERILATOR) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- src/dll.sv
`timescale 1ns/1ps

module dll import track_pkg::*; #(
   parameter int unsigned          DLL_SHIFT  = track_pkg::DLL_SHIFT,
   parameter int unsigned          AID_SHIFT  = track_pkg::AID_SHIFT,
   parameter logic [CA_INC_W-1:0]  CA_NOMINAL = track_pkg::CA_NOMINAL
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     start,
   input  logic [IQ_W-1:0]          iq_early,
   input  logic [IQ_W-1:0]          iq_late,
   input  logic signed [W_DF_W-1:0] w_df_kp1,
   output logic                     done,
   output logic [CA_INC_W-1:0]      ca_dphi
);

   localparam int DISC_W = IQ_W + 1;

   logic [1:0]                 vld;
   logic signed [DISC_W-1:0]   disc;
   logic signed [DISC_W-1:0]   disc_q;
   logic signed [W_DF_W-1:0]   aid_q;
   logic signed [CA_INC_W-1:0] disc_ext;

   always_ff @(posedge clk) begin
      if (rst) begin
         vld <= '0;
      end else begin
         vld <= {vld[0], start};
      end
   end

   assign done = vld[1];

   ////////////////////
   // Stage 1
   ////////////////////

   // Early minus late needs one bit more so the sign survives.
   assign disc = $signed({1'b0, iq_early}) - $signed({1'b0, iq_late});

   // Carrier aiding scales the new FLL frequency down to code rate.
   always_ff @(posedge clk) begin
      disc_q <= disc >>> DLL_SHIFT;
      aid_q  <= w_df_kp1 >>> AID_SHIFT;
   end

   ////////////////////
   // Stage 2
   ////////////////////

   assign disc_ext = CA_INC_W'(disc_q);

   // Sum wraps at the NCO width.
   always_ff @(posedge clk) begin
      ca_dphi <= CA_NOMINAL + disc_ext + CA_INC_W'(aid_q);
   end

endmodule

//--- src/fll.sv
`timescale 1ns/1ps

module fll import track_pkg::*; #(
   parameter int unsigned FLL_SHIFT     = track_pkg::FLL_SHIFT,
   parameter int unsigned DOT_SHIFT     = track_pkg::DOT_SHIFT,
   parameter int unsigned DOPPLER_SHIFT = track_pkg::DOPPLER_SHIFT
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         start,
   input  logic signed [ACC_W-1:0]      i_k,
   input  logic signed [ACC_W-1:0]      q_k,
   input  logic signed [ACC_W-1:0]      i_km1,
   input  logic signed [ACC_W-1:0]      q_km1,
   input  logic signed [W_DF_W-1:0]     w_df_k,
   input  logic signed [W_DF_DOT_W-1:0] w_df_dot_k,
   output logic                         done,
   output fll_out_t                     res
);

   localparam int PROD_W  = 2 * ACC_W;
   localparam int CROSS_W = PROD_W + 1;

   logic [2:0]                   vld;
   logic signed [PROD_W-1:0]     prod_a;
   logic signed [PROD_W-1:0]     prod_b;
   logic signed [CROSS_W-1:0]    cross_q;
   logic signed [CROSS_W-1:0]    cross_f;
   logic signed [CROSS_W-1:0]    cross_d;
   logic signed [W_DF_W-1:0]     w_df_n;
   logic signed [W_DF_DOT_W-1:0] w_df_dot_n;

   // Valid bit follows each epoch through the three stages.
   always_ff @(posedge clk) begin
      if (rst) begin
         vld <= '0;
      end else begin
         vld <= {vld[1:0], start};
      end
   end

   assign done = vld[2];

   ////////////////////
   // Discriminator
   ////////////////////

   // Stage 1. Products of the previous and current prompt samples.
   always_ff @(posedge clk) begin
      prod_a <= i_km1 * q_k;
      prod_b <= q_km1 * i_k;
   end

   // Stage 2. The cross product is proportional to the phase advance.
   always_ff @(posedge clk) begin
      cross_q <= prod_a - prod_b;
   end

   ////////////////////
   // Loop update
   ////////////////////

   // Loop state wraps modulo its width.
   always_comb begin
      cross_f    = cross_q >>> FLL_SHIFT;
      cross_d    = cross_q >>> DOT_SHIFT;
      w_df_n     = w_df_k + cross_f[W_DF_W-1:0];
      w_df_dot_n = w_df_dot_k + cross_d[W_DF_DOT_W-1:0];
   end

   // Stage 3.
   always_ff @(posedge clk) begin
      res.w_df        <= w_df_n;
      res.w_df_dot    <= w_df_dot_n;
      res.doppler_inc <= DOPPLER_W'(w_df_n >>> DOPPLER_SHIFT);
   end

endmodule

//--- src/isqrt.sv
`timescale 1ns/1ps

module isqrt import track_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              start,
   input  logic [I2Q2_W-1:0] radicand,
   output logic              done,
   output logic [IQ_W-1:0]   root
);

   localparam int REM_W = IQ_W + 2;
   localparam int CNT_W = $clog2(IQ_W);

   logic             busy;
   logic [CNT_W-1:0] count;
   logic [I2Q2_W-1:0] rad_q;
   logic [REM_W-1:0] rem_q;
   logic [IQ_W-1:0]  root_q;
   logic [REM_W+1:0] rem_shift;
   logic [REM_W+1:0] trial;
   logic [REM_W+1:0] diff;
   logic             fits;

   ////////////////////
   // Digit step
   ////////////////////

   // Bring down the next two radicand bits and try a 1 in the next root bit.
   always_comb begin
      rem_shift = {rem_q, rad_q[I2Q2_W-1 -: 2]};
      trial     = {2'b00, root_q, 2'b01};
      diff      = rem_shift - trial;
      fits      = (rem_shift >= trial);
   end

   ////////////////////
   // Sequencing
   ////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         busy  <= 1'b0;
         count <= '0;
         done  <= 1'b0;
      end else begin
         done <= 1'b0;
         if (start) begin
            busy  <= 1'b1;
            count <= '0;
         end else if (busy) begin
            count <= count + 1'b1;
            // Last root bit settles on this edge.
            if (count == CNT_W'(IQ_W - 1)) begin
               busy <= 1'b0;
               done <= 1'b1;
            end
         end
      end
   end

   // Remainder never exceeds 2*root, so REM_W bits hold it.
   always_ff @(posedge clk) begin
      if (start) begin
         rad_q  <= radicand;
         rem_q  <= '0;
         root_q <= '0;
      end else if (busy) begin
         rad_q <= {rad_q[I2Q2_W-3:0], 2'b00};
         if (fits) begin
            rem_q  <= diff[REM_W-1:0];
            root_q <= {root_q[IQ_W-2:0], 1'b1};
         end else begin
            rem_q  <= rem_shift[REM_W-1:0];
            root_q <= {root_q[IQ_W-2:0], 1'b0};
         end
      end
   end

   assign root = root_q;

   // The controller must wait for done before the next operand.
   a_no_restart: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
      else $error("isqrt started while busy");

endmodule

//--- src/track_ctrl.sv
`timescale 1ns/1ps

module track_ctrl import track_pkg::*; (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     in_req,
   output logic                     in_ack,
   input  epoch_t                   epoch,
   output logic                     res_req,
   input  logic                     res_ack,
   output result_t                  result,
   output logic                     sqrt_start,
   input  logic                     sqrt_done,
   input  logic [IQ_W-1:0]          iq_early,
   input  logic [IQ_W-1:0]          iq_prompt,
   input  logic [IQ_W-1:0]          iq_late,
   output logic                     fll_start,
   input  logic                     fll_done,
   input  fll_out_t                 fll_res,
   output logic                     dll_start,
   input  logic                     dll_done,
   input  logic [CA_INC_W-1:0]      ca_dphi,
   output epoch_t                   ep,
   output logic [IQ_W-1:0]          iq_early_q,
   output logic [IQ_W-1:0]          iq_late_q,
   output logic signed [W_DF_W-1:0] w_df_kp1_q
);

   typedef enum logic [2:0] {IDLE, ROOT, FLL, DLL, REPORT, RELEASE} state_t;

   state_t                state;
   logic                  accept;
   logic [IQ_W-1:0]       iq_prompt_q;
   fll_out_t              fll_q;
   logic [CA_INC_W-1:0]   ca_q;

   // New epoch only once the previous result handshake is back to idle.
   assign accept = (state == IDLE) && in_req && !in_ack;

   ////////////////////
   // Sequencer
   ////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= IDLE;
         in_ack     <= 1'b0;
         res_req    <= 1'b0;
         sqrt_start <= 1'b0;
         fll_start  <= 1'b0;
         dll_start  <= 1'b0;
      end else begin
         sqrt_start <= 1'b0;
         fll_start  <= 1'b0;
         dll_start  <= 1'b0;
         // Input side closes on its own once the source lets go.
         if (in_ack && !in_req) begin
            in_ack <= 1'b0;
         end
         case (state)
            IDLE: begin
               if (accept) begin
                  in_ack     <= 1'b1;
                  sqrt_start <= 1'b1;
                  state      <= ROOT;
               end
            end
            ROOT: begin
               if (sqrt_done) begin
                  fll_start <= 1'b1;
                  state     <= FLL;
               end
            end
            // DLL needs the new frequency for aiding.
            FLL: begin
               if (fll_done) begin
                  dll_start <= 1'b1;
                  state     <= DLL;
               end
            end
            DLL: begin
               if (dll_done) begin
                  res_req <= 1'b1;
                  state   <= REPORT;
               end
            end
            REPORT: begin
               if (res_ack) begin
                  res_req <= 1'b0;
                  state   <= RELEASE;
               end
            end
            RELEASE: begin
               if (!res_ack) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   ////////////////////
   // Result registers
   ////////////////////

   always_ff @(posedge clk) begin
      if (accept) begin
         ep <= epoch;
      end
      if (state == ROOT && sqrt_done) begin
         iq_early_q  <= iq_early;
         iq_prompt_q <= iq_prompt;
         iq_late_q   <= iq_late;
      end
      if (state == FLL && fll_done) begin
         fll_q <= fll_res;
      end
      if (state == DLL && dll_done) begin
         ca_q <= ca_dphi;
      end
   end

   assign w_df_kp1_q = fll_q.w_df;

   always_comb begin
      result.iq_prompt_k  = iq_prompt_q;
      result.doppler_inc  = fll_q.doppler_inc;
      result.w_df_kp1     = fll_q.w_df;
      result.w_df_dot_kp1 = fll_q.w_df_dot;
      result.ca_dphi      = ca_q;
   end

   ////////////////////
   // Checks
   ////////////////////

   // Each unit answers at its fixed latency, so no start is left outstanding.
   a_sqrt_once: assert property (@(posedge clk) disable iff (rst)
      sqrt_start |-> ##(IQ_W + 1) sqrt_done)
      else $error("sqrt_done did not follow sqrt_start at its fixed latency");
   a_fll_once: assert property (@(posedge clk) disable iff (rst)
      fll_start |-> ##3 fll_done)
      else $error("fll_done did not follow fll_start at its fixed latency");
   a_dll_once: assert property (@(posedge clk) disable iff (rst)
      dll_start |-> ##2 dll_done)
      else $error("dll_done did not follow dll_start at its fixed latency");

   // Result is held until the sink takes it.
   a_res_hold: assert property (@(posedge clk) disable iff (rst)
      res_req && !res_ack |=> res_req && $stable(result))
      else $error("res_req dropped or result changed before res_ack");

endmodule

//--- src/track_pkg.sv
package track_pkg;

   ////////////////////
   // Widths
   ////////////////////

   localparam int I2Q2_W     = 32;
   localparam int IQ_W       = 16;
   localparam int ACC_W      = 16;
   localparam int W_DF_W     = 24;
   localparam int W_DF_DOT_W = 24;
   localparam int DOPPLER_W  = 24;
   localparam int CA_INC_W   = 24;

   ////////////////////
   // Channel records
   ////////////////////

   // One epoch of channel history, as handed over on the input handshake.
   typedef struct packed {
      logic        [I2Q2_W-1:0]     i2q2_early;
      logic        [I2Q2_W-1:0]     i2q2_prompt;
      logic        [I2Q2_W-1:0]     i2q2_late;
      logic        [IQ_W-1:0]       iq_prompt_km1;
      logic signed [ACC_W-1:0]      i_prompt_k;
      logic signed [ACC_W-1:0]      q_prompt_k;
      logic signed [ACC_W-1:0]      i_prompt_km1;
      logic signed [ACC_W-1:0]      q_prompt_km1;
      logic signed [W_DF_W-1:0]     w_df_k;
      logic signed [W_DF_DOT_W-1:0] w_df_dot_k;
   } epoch_t;

   // Loop outputs returned to the channel history.
   typedef struct packed {
      logic        [IQ_W-1:0]       iq_prompt_k;
      logic signed [DOPPLER_W-1:0]  doppler_inc;
      logic signed [W_DF_W-1:0]     w_df_kp1;
      logic signed [W_DF_DOT_W-1:0] w_df_dot_kp1;
      logic        [CA_INC_W-1:0]   ca_dphi;
   } result_t;

   // New frequency state from the FLL.
   typedef struct packed {
      logic signed [DOPPLER_W-1:0]  doppler_inc;
      logic signed [W_DF_W-1:0]     w_df;
      logic signed [W_DF_DOT_W-1:0] w_df_dot;
   } fll_out_t;

   ////////////////////
   // Default gains
   ////////////////////

   // Loop gains are powers of two, given as right shifts.
   localparam int unsigned FLL_SHIFT     = 8;
   localparam int unsigned DOT_SHIFT     = 12;
   localparam int unsigned DOPPLER_SHIFT = 4;
   localparam int unsigned DLL_SHIFT     = 2;
   localparam int unsigned AID_SHIFT     = 6;

   // Nominal C/A code phase increment per epoch.
   localparam logic [CA_INC_W-1:0] CA_NOMINAL = 24'h200000;

endpackage

//--- src/tracking_loops.sv
`timescale 1ns/1ps

module tracking_loops import track_pkg::*; #(
   parameter int unsigned         FLL_SHIFT     = track_pkg::FLL_SHIFT,
   parameter int unsigned         DOT_SHIFT     = track_pkg::DOT_SHIFT,
   parameter int unsigned         DOPPLER_SHIFT = track_pkg::DOPPLER_SHIFT,
   parameter int unsigned         DLL_SHIFT     = track_pkg::DLL_SHIFT,
   parameter int unsigned         AID_SHIFT     = track_pkg::AID_SHIFT,
   parameter logic [CA_INC_W-1:0] CA_NOMINAL    = track_pkg::CA_NOMINAL
) (
   input  logic    clk,
   input  logic    rst,
   input  logic    in_req,
   output logic    in_ack,
   input  epoch_t  epoch,
   output logic    res_req,
   input  logic    res_ack,
   output result_t result
);

   logic                     sqrt_start;
   logic                     sqrt_done;
   logic                     done_early;
   logic                     done_prompt;
   logic                     done_late;
   logic [IQ_W-1:0]          iq_early;
   logic [IQ_W-1:0]          iq_prompt;
   logic [IQ_W-1:0]          iq_late;
   logic                     fll_start;
   logic                     fll_done;
   fll_out_t                 fll_res;
   logic                     dll_start;
   logic                     dll_done;
   logic [CA_INC_W-1:0]      ca_dphi;
   epoch_t                   ep;
   logic [IQ_W-1:0]          iq_early_q;
   logic [IQ_W-1:0]          iq_late_q;
   logic signed [W_DF_W-1:0] w_df_kp1_q;

   track_ctrl u_ctrl (
      .clk, .rst, .in_req, .in_ack, .epoch, .res_req, .res_ack, .result,
      .sqrt_start, .sqrt_done, .iq_early, .iq_prompt, .iq_late,
      .fll_start, .fll_done, .fll_res, .dll_start, .dll_done, .ca_dphi,
      .ep, .iq_early_q, .iq_late_q, .w_df_kp1_q
   );

   ////////////////////
   // Magnitudes
   ////////////////////

   // All three roots start together and take the same cycle count.
   isqrt root_early (.clk, .rst, .start(sqrt_start), .radicand(ep.i2q2_early),
                     .done(done_early), .root(iq_early));
   isqrt root_prompt (.clk, .rst, .start(sqrt_start), .radicand(ep.i2q2_prompt),
                      .done(done_prompt), .root(iq_prompt));
   isqrt root_late (.clk, .rst, .start(sqrt_start), .radicand(ep.i2q2_late),
                    .done(done_late), .root(iq_late));

   assign sqrt_done = done_early & done_prompt & done_late;

   ////////////////////
   // Loops
   ////////////////////

   fll #(.FLL_SHIFT(FLL_SHIFT), .DOT_SHIFT(DOT_SHIFT), .DOPPLER_SHIFT(DOPPLER_SHIFT)) u_fll (
      .clk, .rst, .start(fll_start),
      .i_k(ep.i_prompt_k), .q_k(ep.q_prompt_k),
      .i_km1(ep.i_prompt_km1), .q_km1(ep.q_prompt_km1),
      .w_df_k(ep.w_df_k), .w_df_dot_k(ep.w_df_dot_k),
      .done(fll_done), .res(fll_res)
   );

   dll #(.DLL_SHIFT(DLL_SHIFT), .AID_SHIFT(AID_SHIFT), .CA_NOMINAL(CA_NOMINAL)) u_dll (
      .clk, .rst, .start(dll_start),
      .iq_early(iq_early_q), .iq_late(iq_late_q), .w_df_kp1(w_df_kp1_q),
      .done(dll_done), .ca_dphi
   );

endmodule

//--- tb.f
src/track_pkg.sv
src/isqrt.sv
src/fll.sv
src/dll.sv
src/track_ctrl.sv
src/tracking_loops.sv
tb/tb_tracking_loops.sv

//--- tb/tb_tracking_loops.sv
`timescale 1ns/1ps

module tb_tracking_loops import track_pkg::*; ();

   localparam int NUM_REC   = 10;
   localparam int REC_WORDS = 16;
   localparam int TIMEOUT   = 200;

   logic    clk;
   logic    rst;
   logic    in_req;
   logic    in_ack;
   epoch_t  epoch;
   logic    res_req;
   logic    res_ack;
   result_t result;

   logic [31:0] stim_mem [0:NUM_REC*REC_WORDS-1];
   logic [15:0] lfsr;

   int checks;
   int value_errors;
   int protocol_errors;
   int timeouts;
   int results_seen;
   bit abort;

   // Handshake monitor state.
   logic in_ack_d;
   logic res_req_d;
   logic res_ack_d;
   int   accepted;
   int   returned;
   int   monitor_errors;

   tracking_loops uut (
      .clk, .rst, .in_req, .in_ack, .epoch, .res_req, .res_ack, .result
   );

   always #2 clk = ~clk;

   ////////////////////
   // Stimulus helpers
   ////////////////////

   // Taps 16, 14, 13 and 11.
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic take_random(input int nbits, output int value);
      value = 0;
      for (int i = 0; i < nbits; i++) begin
         lfsr  = lfsr_step(lfsr);
         value = (value << 1) | int'(lfsr[0]);
      end
   endtask

   // Words 0 to 9 of a record.
   function automatic epoch_t epoch_from_file(input int k);
      epoch_t e;
      int     b;
      b = k * REC_WORDS;
      e.i2q2_early    = stim_mem[b];
      e.i2q2_prompt   = stim_mem[b+1];
      e.i2q2_late     = stim_mem[b+2];
      e.iq_prompt_km1 = stim_mem[b+3][IQ_W-1:0];
      e.i_prompt_k    = stim_mem[b+4][ACC_W-1:0];
      e.q_prompt_k    = stim_mem[b+5][ACC_W-1:0];
      e.i_prompt_km1  = stim_mem[b+6][ACC_W-1:0];
      e.q_prompt_km1  = stim_mem[b+7][ACC_W-1:0];
      e.w_df_k        = stim_mem[b+8][W_DF_W-1:0];
      e.w_df_dot_k    = stim_mem[b+9][W_DF_DOT_W-1:0];
      return e;
   endfunction

   // Words 10 to 14 of a record.
   function automatic result_t result_from_file(input int k);
      result_t r;
      int      b;
      b = k * REC_WORDS;
      r.iq_prompt_k  = stim_mem[b+10][IQ_W-1:0];
      r.doppler_inc  = stim_mem[b+11][DOPPLER_W-1:0];
      r.w_df_kp1     = stim_mem[b+12][W_DF_W-1:0];
      r.w_df_dot_kp1 = stim_mem[b+13][W_DF_DOT_W-1:0];
      r.ca_dphi      = stim_mem[b+14][CA_INC_W-1:0];
      return r;
   endfunction

   function automatic int ack_delay(input int k);
      return int'(stim_mem[k*REC_WORDS+15]);
   endfunction

   task automatic wait_in_ack(input logic level);
      int n;
      bit seen;
      n    = 0;
      seen = 1'b0;
      while (!seen && !abort && n < TIMEOUT) begin
         @(posedge clk);
         seen = (in_ack === level);
         n++;
      end
      if (!seen && !abort) begin
         timeouts++;
         abort = 1'b1;
         $display("Timeout: in_ack did not go to %b within %0d cycles", level, TIMEOUT);
      end
   endtask

   task automatic wait_res_req(input logic level);
      int n;
      bit seen;
      n    = 0;
      seen = 1'b0;
      while (!seen && !abort && n < TIMEOUT) begin
         @(posedge clk);
         seen = (res_req === level);
         n++;
      end
      if (!seen && !abort) begin
         timeouts++;
         abort = 1'b1;
         $display("Timeout: res_req did not go to %b within %0d cycles", level, TIMEOUT);
      end
   endtask

   ////////////////////
   // Source and sink
   ////////////////////

   task automatic drive_epochs();
      int extra;
      for (int k = 0; k < NUM_REC && !abort; k++) begin
         @(posedge clk);
         epoch  <= epoch_from_file(k);
         in_req <= 1'b1;
         wait_in_ack(1'b1);
         // Hold the request a few random cycles past the ack.
         take_random(2, extra);
         repeat (extra) @(posedge clk);
         in_req <= 1'b0;
         wait_in_ack(1'b0);
      end
   endtask

   task automatic collect_results();
      result_t want;
      result_t held;
      int      delay;
      for (int k = 0; k < NUM_REC && !abort; k++) begin
         want  = result_from_file(k);
         delay = ack_delay(k);
         wait_res_req(1'b1);
         if (!abort) begin
            results_seen++;
            checks += 5;
            if (result.iq_prompt_k !== want.iq_prompt_k) begin
               value_errors++;
               $display("Error: epoch %0d iq_prompt_k expected %h actual %h",
                        k, want.iq_prompt_k, result.iq_prompt_k);
            end
            if (result.doppler_inc !== want.doppler_inc) begin
               value_errors++;
               $display("Error: epoch %0d doppler_inc expected %h actual %h",
                        k, want.doppler_inc, result.doppler_inc);
            end
            if (result.w_df_kp1 !== want.w_df_kp1) begin
               value_errors++;
               $display("Error: epoch %0d w_df_kp1 expected %h actual %h",
                        k, want.w_df_kp1, result.w_df_kp1);
            end
            if (result.w_df_dot_kp1 !== want.w_df_dot_kp1) begin
               value_errors++;
               $display("Error: epoch %0d w_df_dot_kp1 expected %h actual %h",
                        k, want.w_df_dot_kp1, result.w_df_dot_kp1);
            end
            if (result.ca_dphi !== want.ca_dphi) begin
               value_errors++;
               $display("Error: epoch %0d ca_dphi expected %h actual %h",
                        k, want.ca_dphi, result.ca_dphi);
            end
            held = result;
            // The result must stay put while the sink is slow.
            repeat (delay) begin
               @(posedge clk);
               if (res_req !== 1'b1 || result !== held) begin
                  protocol_errors++;
                  $display("Epoch %0d result was not held while res_ack was low", k);
               end
            end
            res_ack <= 1'b1;
            wait_res_req(1'b0);
            res_ack <= 1'b0;
         end
      end
   endtask

   ////////////////////
   // Handshake monitor
   ////////////////////

   always @(posedge clk) begin
      if (rst) begin
         accepted       = 0;
         returned       = 0;
         monitor_errors = 0;
      end else begin
         if (in_ack && !in_ack_d) begin
            if (!in_req) begin
               monitor_errors++;
               $display("in_ack rose while in_req was low");
            end
            // Back-pressure. No new epoch before the last result is released.
            if (accepted != returned) begin
               monitor_errors++;
               $display("in_ack for epoch %0d rose before result %0d was released",
                        accepted, returned);
            end
            accepted++;
         end
         if (!res_req && res_req_d && !res_ack) begin
            monitor_errors++;
            $display("res_req dropped before res_ack was seen");
         end
         if (!res_ack && res_ack_d) begin
            returned++;
         end
      end
      in_ack_d  <= in_ack;
      res_req_d <= res_req;
      res_ack_d <= res_ack;
   end

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      clk             = 1'b0;
      rst             = 1'b1;
      in_req          = 1'b0;
      res_ack         = 1'b0;
      epoch           = '0;
      lfsr            = 16'd40;
      checks          = 0;
      value_errors    = 0;
      protocol_errors = 0;
      timeouts        = 0;
      results_seen    = 0;
      abort           = 1'b0;
      $readmemh("tb/track_stimulus.dat", stim_mem);

      repeat (10) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      if (in_ack !== 1'b0 || res_req !== 1'b0) begin
         protocol_errors++;
         $display("in_ack or res_req was not low after reset");
      end

      fork
         drive_epochs();
         collect_results();
      join

      repeat (4) @(posedge clk);
      if (results_seen != NUM_REC) begin
         protocol_errors++;
         $display("Only %0d of %0d results came back", results_seen, NUM_REC);
      end

      $display("Checks %0d, value errors %0d, protocol errors %0d, timeouts %0d",
               checks, value_errors, protocol_errors + monitor_errors, timeouts);
      if (value_errors + protocol_errors + monitor_errors + timeouts == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- tb/track_stimulus.dat
// i2q2_e i2q2_p i2q2_l iq_km1 i_k q_k i_km1 q_km1 w_df w_df_dot, then expected
// iq_prompt doppler_inc w_df_kp1 w_df_dot_kp1 ca_dphi, then res_ack delay in cycles
// All zero.
00000000 00000000 00000000 0000 0000 0000 0000 0000 000000 000000 0000 000000 000000 000000 200000 00
// Perfect squares, positive cross, early above late.
00027100 000F4240 00015F90 03DE 0384 01F4 03E8 00C8 0003E8 000032 03E8 00008C 0008CA 000080 20003C 00
// Negative cross, early below late.
0000F424 001E8480 00010810 03E8 044C FED4 04B0 0190 0008CA 000080 0586 FFFFC9 FFFC95 FFFFBC 1FFFEF 05
// Largest radicand, zero cross.
FFFFFFFF FFFFFFFF 00000000 0586 00C8 00C8 012C 012C FFFC95 FFFFBC FFFF FFFFC9 FFFC95 FFFFBC 203FF1 0C
// Full scale samples, near maximum cross.
00000008 075BCD15 00000003 FFFF 8000 8000 8000 7FFF 000000 FFFC18 2B67 07FFF8 7FFF80 07FC10 21FFFE 01
00000F4240 0000000F 000EA600 2B67 0002 FFF9 0005 0003 000064 000000 0003 000006 000063 FFFFFF 200006 03
// Late at full scale, zero cross.
00000000 FFFE0001 FFFFFFFF 0003 FF9C FF9C FF9C FF9C FFFFF0 000007 FFFF FFFFFF FFFFF0 000007 1FBFFF 00
00000002 40000000 00000000 FFFF 0028 001E 000A FFEC FFFFF0 000007 8000 FFFFFF FFFFF4 000007 1FFFFF 14
00002710 00000063 000009C4 8000 0000 0100 0100 0000 000400 07FC10 0009 000050 000500 07FC20 200020 07
00010000 00000001 00010000 0009 0001 0001 FFFF 0001 000000 000000 0001 FFFFFF FFFFFF FFFFFF 1FFFFF 02
